// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= oc_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' tb.f) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) tb.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/oc_params.svh ====
`ifndef OC_PARAMS_SVH
`define OC_PARAMS_SVH

// lanes per warp and bits per lane
`define OC_LANES        8
`define OC_LANE_W       32

// register file geometry, 64 registers over 4 banks
`define OC_WARPS        8
`define OC_REGS         8
`define OC_BANKS        4

// collector units
`define OC_COLLECTORS   4

// 4 collectors x 2 operands, so a bank queue can never overflow
`define OC_QUEUE_DEPTH  8

`endif

// ==== src/dispatch_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module dispatch_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`OC_COLLECTORS-1:0]              ready,
    input  oc_pkg::instr_t [`OC_COLLECTORS-1:0]    instr,
    input  oc_pkg::warp_id_t [`OC_COLLECTORS-1:0]  warp,
    input  oc_pkg::reg_idx_t [`OC_COLLECTORS-1:0]  dst,
    input  oc_pkg::alu_op_t [`OC_COLLECTORS-1:0]   op,
    input  oc_pkg::lane_vec_t [`OC_COLLECTORS-1:0] opnd1,
    input  oc_pkg::lane_vec_t [`OC_COLLECTORS-1:0] opnd2,
    output logic [`OC_COLLECTORS-1:0]              grant,
    output logic                                   alu_valid,
    output oc_pkg::instr_t                         alu_instr,
    output oc_pkg::warp_id_t                       alu_warp,
    output oc_pkg::reg_idx_t                       alu_dst,
    output oc_pkg::alu_op_t                        alu_op,
    output oc_pkg::lane_vec_t                      alu_src1,
    output oc_pkg::lane_vec_t                      alu_src2
);
    import oc_pkg::*;

    cid_t ptr;      // first entry looked at this cycle
    cid_t sel;
    logic found;

    always_comb begin
        found = 1'b0;
        sel   = ptr;
        for (int k = 0; k < `OC_COLLECTORS; k++) begin
            if (!found && ready[ptr + cid_t'(k)]) begin
                found = 1'b1;
                sel   = ptr + cid_t'(k);
            end
        end
        grant      = '0;
        grant[sel] = found;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr       <= '0;
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= found;
            if (found) begin
                ptr <= sel + cid_t'(1);       // winner drops to lowest priority
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            alu_instr <= instr[sel];
            alu_warp  <= warp[sel];
            alu_dst   <= dst[sel];
            alu_op    <= op[sel];
            alu_src1  <= opnd1[sel];
            alu_src2  <= opnd2[sel];
        end
    end

endmodule

`default_nettype wire

// ==== src/oc_pkg.sv ====
`default_nettype none

`include "oc_params.svh"

package oc_pkg;

    typedef logic [`OC_LANES*`OC_LANE_W-1:0] lane_vec_t;   // one register, all lanes
    typedef logic [$clog2(`OC_WARPS)-1:0] warp_id_t;
    typedef logic [$clog2(`OC_REGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`OC_BANKS)-1:0] bank_id_t;
    typedef logic [$clog2(`OC_WARPS*`OC_REGS/`OC_BANKS)-1:0] row_id_t;
    typedef logic [$clog2(`OC_COLLECTORS)-1:0] cid_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [31:0] instr_t;              // carried through untouched

    // the same 6 bits seen as {warp, reg} or as {row, bank}
    typedef union packed {
        struct packed {
            warp_id_t warp;
            reg_idx_t idx;
        } flat;
        struct packed {
            row_id_t  row;
            bank_id_t bank;                    // low bits spread a warp over the banks
        } banked;
    } phys_addr_u;

endpackage

`default_nettype wire

// ==== src/operand_collector_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module operand_collector_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  oc_pkg::instr_t    in_instr,
    input  oc_pkg::warp_id_t  in_warp,
    input  oc_pkg::reg_idx_t  in_dst,
    input  oc_pkg::alu_op_t   in_alu_op,
    input  oc_pkg::reg_idx_t  in_src1,
    input  logic              in_src1_valid,
    input  oc_pkg::reg_idx_t  in_src2,
    input  logic              in_src2_valid,
    input  logic [15:0]       in_imm,
    input  logic              in_imm_valid,
    output logic              full,
    input  logic              wb_valid,
    input  oc_pkg::warp_id_t  wb_warp,
    input  oc_pkg::reg_idx_t  wb_reg,
    input  oc_pkg::lane_vec_t wb_data,
    output logic              alu_valid,
    output oc_pkg::instr_t    alu_instr,
    output oc_pkg::warp_id_t  alu_warp,
    output oc_pkg::reg_idx_t  alu_dst,
    output oc_pkg::alu_op_t   alu_op,
    output oc_pkg::lane_vec_t alu_src1,
    output oc_pkg::lane_vec_t alu_src2
);
    import oc_pkg::*;

    // issue stage outputs
    logic                            alloc_valid;
    cid_t                            alloc_cid;
    instr_t                          alloc_instr;
    warp_id_t                        alloc_warp;
    reg_idx_t                        alloc_dst;
    alu_op_t                         alloc_op;
    logic [1:0]                      alloc_need;
    lane_vec_t                       alloc_preset1;
    lane_vec_t                       alloc_preset2;
    logic [`OC_BANKS-1:0][1:0]       req_valid;
    row_id_t [`OC_BANKS-1:0][1:0]    req_row;
    cid_t                            req_cid;
    logic [`OC_BANKS-1:0][1:0]       req_slot;

    // bank side
    phys_addr_u                      wb_addr;
    logic [`OC_BANKS-1:0]            wr_valid;
    logic [`OC_BANKS-1:0]            ret_valid;
    cid_t [`OC_BANKS-1:0]            ret_cid;
    logic [`OC_BANKS-1:0]            ret_slot;
    lane_vec_t [`OC_BANKS-1:0]       ret_data;

    // collector entries
    logic [`OC_COLLECTORS-1:0]       busy;
    logic [`OC_COLLECTORS-1:0]       ready;
    logic [`OC_COLLECTORS-1:0]       grant;
    instr_t [`OC_COLLECTORS-1:0]     instr;
    warp_id_t [`OC_COLLECTORS-1:0]   warp;
    reg_idx_t [`OC_COLLECTORS-1:0]   dst;
    alu_op_t [`OC_COLLECTORS-1:0]    op;
    lane_vec_t [`OC_COLLECTORS-1:0]  opnd1;
    lane_vec_t [`OC_COLLECTORS-1:0]  opnd2;

    // writeback goes to exactly one bank
    always_comb begin
        wb_addr.flat.warp = wb_warp;
        wb_addr.flat.idx  = wb_reg;
        for (int b = 0; b < `OC_BANKS; b++) begin
            wr_valid[b] = wb_valid && (wb_addr.banked.bank == bank_id_t'(b));
        end
    end

    operand_issue u_issue (.*);

    for (genvar b = 0; b < `OC_BANKS; b++) begin : g_bank
        register_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_valid  (wr_valid[b]),
            .wr_row    (wb_addr.banked.row),
            .wr_data   (wb_data),
            .req_valid (req_valid[b]),
            .req_row   (req_row[b]),
            .req_cid   (req_cid),
            .req_slot  (req_slot[b]),
            .ret_valid (ret_valid[b]),
            .ret_cid   (ret_cid[b]),
            .ret_slot  (ret_slot[b]),
            .ret_data  (ret_data[b])
        );
    end

    operand_collectors u_collectors (.*);

    dispatch_arbiter u_dispatch (.*);

endmodule

`default_nettype wire

// ==== src/operand_collectors.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module operand_collectors (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     alloc_valid,
    input  oc_pkg::cid_t                             alloc_cid,
    input  oc_pkg::instr_t                           alloc_instr,
    input  oc_pkg::warp_id_t                         alloc_warp,
    input  oc_pkg::reg_idx_t                         alloc_dst,
    input  oc_pkg::alu_op_t                          alloc_op,
    input  logic [1:0]                               alloc_need,
    input  oc_pkg::lane_vec_t                        alloc_preset1,
    input  oc_pkg::lane_vec_t                        alloc_preset2,
    input  logic [`OC_BANKS-1:0]                     ret_valid,
    input  oc_pkg::cid_t [`OC_BANKS-1:0]             ret_cid,
    input  logic [`OC_BANKS-1:0]                     ret_slot,
    input  oc_pkg::lane_vec_t [`OC_BANKS-1:0]        ret_data,
    input  logic [`OC_COLLECTORS-1:0]                grant,
    output logic [`OC_COLLECTORS-1:0]                busy,
    output logic [`OC_COLLECTORS-1:0]                ready,
    output oc_pkg::instr_t [`OC_COLLECTORS-1:0]      instr,
    output oc_pkg::warp_id_t [`OC_COLLECTORS-1:0]    warp,
    output oc_pkg::reg_idx_t [`OC_COLLECTORS-1:0]    dst,
    output oc_pkg::alu_op_t [`OC_COLLECTORS-1:0]     op,
    output oc_pkg::lane_vec_t [`OC_COLLECTORS-1:0]   opnd1,
    output oc_pkg::lane_vec_t [`OC_COLLECTORS-1:0]   opnd2
);
    import oc_pkg::*;

    logic [`OC_COLLECTORS-1:0]      valid;
    logic [`OC_COLLECTORS-1:0][1:0] pend;  // slots still owed by a bank

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            pend  <= '0;
        end else begin
            for (int c = 0; c < `OC_COLLECTORS; c++) begin
                if (grant[c]) begin
                    valid[c] <= 1'b0;
                end
                if (alloc_valid && alloc_cid == cid_t'(c)) begin
                    valid[c] <= 1'b1;
                    pend[c]  <= alloc_need;
                end
                for (int b = 0; b < `OC_BANKS; b++) begin
                    if (ret_valid[b] && ret_cid[b] == cid_t'(c)) begin
                        pend[c][ret_slot[b]] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `OC_COLLECTORS; c++) begin
            if (alloc_valid && alloc_cid == cid_t'(c)) begin
                instr[c] <= alloc_instr;
                warp[c]  <= alloc_warp;
                dst[c]   <= alloc_dst;
                op[c]    <= alloc_op;
                opnd1[c] <= alloc_preset1;     // overwritten when a read is needed
                opnd2[c] <= alloc_preset2;
            end
            // banks return in parallel, possibly both slots of one entry
            for (int b = 0; b < `OC_BANKS; b++) begin
                if (ret_valid[b] && ret_cid[b] == cid_t'(c)) begin
                    if (ret_slot[b]) begin
                        opnd2[c] <= ret_data[b];
                    end else begin
                        opnd1[c] <= ret_data[b];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `OC_COLLECTORS; c++) begin
            ready[c] = valid[c] && (pend[c] == 2'b00);
        end
    end

    assign busy = valid;

endmodule

`default_nettype wire

// ==== src/operand_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module operand_issue (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  oc_pkg::instr_t                       in_instr,
    input  oc_pkg::warp_id_t                     in_warp,
    input  oc_pkg::reg_idx_t                     in_dst,
    input  oc_pkg::alu_op_t                      in_alu_op,
    input  oc_pkg::reg_idx_t                     in_src1,
    input  logic                                 in_src1_valid,
    input  oc_pkg::reg_idx_t                     in_src2,
    input  logic                                 in_src2_valid,
    input  logic [15:0]                          in_imm,
    input  logic                                 in_imm_valid,
    input  logic [`OC_COLLECTORS-1:0]            busy,
    output logic                                 full,
    output logic                                 alloc_valid,
    output oc_pkg::cid_t                         alloc_cid,
    output oc_pkg::instr_t                       alloc_instr,
    output oc_pkg::warp_id_t                     alloc_warp,
    output oc_pkg::reg_idx_t                     alloc_dst,
    output oc_pkg::alu_op_t                      alloc_op,
    output logic [1:0]                           alloc_need,
    output oc_pkg::lane_vec_t                    alloc_preset1,
    output oc_pkg::lane_vec_t                    alloc_preset2,
    output logic [`OC_BANKS-1:0][1:0]            req_valid,
    output oc_pkg::row_id_t [`OC_BANKS-1:0][1:0] req_row,
    output oc_pkg::cid_t                         req_cid,
    output logic [`OC_BANKS-1:0][1:0]            req_slot
);
    import oc_pkg::*;

    localparam int CNT_W = $clog2(`OC_COLLECTORS + 1);

    reg_idx_t             pend_src1;
    reg_idx_t             pend_src2;
    logic                 pend_src1_valid;
    logic                 pend_src2_valid;
    logic [15:0]          pend_imm;
    logic                 pend_imm_valid;
    phys_addr_u           addr1;
    phys_addr_u           addr2;
    logic                 rd1;
    logic                 rd2;
    logic [`OC_BANKS-1:0] hit1;
    logic [`OC_BANKS-1:0] hit2;
    logic [CNT_W-1:0]     n_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= in_valid;           // allocation on the next edge
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            alloc_instr     <= in_instr;
            alloc_warp      <= in_warp;
            alloc_dst       <= in_dst;
            alloc_op        <= in_alu_op;
            pend_src1       <= in_src1;
            pend_src2       <= in_src2;
            pend_src1_valid <= in_src1_valid;
            pend_src2_valid <= in_src2_valid;
            pend_imm        <= in_imm;
            pend_imm_valid  <= in_imm_valid;
        end
    end

    // lowest free collector
    always_comb begin
        alloc_cid = '0;
        n_busy    = '0;
        for (int c = `OC_COLLECTORS - 1; c >= 0; c--) begin
            if (!busy[c]) begin
                alloc_cid = cid_t'(c);
            end
            n_busy = n_busy + CNT_W'(busy[c]);
        end
    end

    assign full = (n_busy + CNT_W'(alloc_valid)) >= CNT_W'(`OC_COLLECTORS);   // pending counts

    assign rd1 = pend_src1_valid;
    assign rd2 = pend_src2_valid && !pend_imm_valid;   // imm replaces src2

    assign alloc_need    = {rd2, rd1};
    assign alloc_preset1 = '0;
    assign alloc_preset2 = pend_imm_valid ? {`OC_LANES{`OC_LANE_W'(pend_imm)}} : '0;
    assign req_cid       = alloc_cid;

    always_comb begin
        addr1.flat.warp = alloc_warp;
        addr1.flat.idx  = pend_src1;
        addr2.flat.warp = alloc_warp;
        addr2.flat.idx  = pend_src2;
        for (int b = 0; b < `OC_BANKS; b++) begin
            hit1[b] = alloc_valid && rd1 && (addr1.banked.bank == bank_id_t'(b));
            hit2[b] = alloc_valid && rd2 && (addr2.banked.bank == bank_id_t'(b));
            // a lone src2 request goes in lane 0
            req_valid[b]   = {hit1[b] && hit2[b], hit1[b] || hit2[b]};
            req_row[b][0]  = hit1[b] ? addr1.banked.row : addr2.banked.row;
            req_slot[b][0] = !hit1[b];
            req_row[b][1]  = addr2.banked.row;
            req_slot[b][1] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/register_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module register_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_valid,
    input  oc_pkg::row_id_t       wr_row,
    input  oc_pkg::lane_vec_t     wr_data,
    input  logic [1:0]            req_valid,
    input  oc_pkg::row_id_t [1:0] req_row,
    input  oc_pkg::cid_t          req_cid,
    input  logic [1:0]            req_slot,
    output logic                  ret_valid,
    output oc_pkg::cid_t          ret_cid,
    output logic                  ret_slot,
    output oc_pkg::lane_vec_t     ret_data
);
    import oc_pkg::*;

    localparam int ROWS  = `OC_WARPS * `OC_REGS / `OC_BANKS;
    localparam int PTR_W = $clog2(`OC_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    lane_vec_t        mem    [ROWS];
    row_id_t          q_row  [`OC_QUEUE_DEPTH];
    cid_t             q_cid  [`OC_QUEUE_DEPTH];
    logic             q_slot [`OC_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_push;
    logic             pop;

    assign pop    = (count != '0);
    assign n_push = CNT_W'(req_valid[0]) + CNT_W'(req_valid[1]);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_row] <= wr_data;
        end
        if (req_valid[0]) begin
            q_row[wr_ptr]  <= req_row[0];
            q_cid[wr_ptr]  <= req_cid;
            q_slot[wr_ptr] <= req_slot[0];
        end
        if (req_valid[1]) begin                // same bank for both sources
            q_row[wr_ptr + 1'b1]  <= req_row[1];
            q_cid[wr_ptr + 1'b1]  <= req_cid;
            q_slot[wr_ptr + 1'b1] <= req_slot[1];
        end
        ret_data <= mem[q_row[rd_ptr]];        // same-edge write lands after this read
        ret_cid  <= q_cid[rd_ptr];
        ret_slot <= q_slot[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            ret_valid <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr + n_push[PTR_W-1:0];
            rd_ptr    <= rd_ptr + PTR_W'(pop);
            count     <= count + n_push - CNT_W'(pop);
            ret_valid <= pop;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
src/oc_pkg.sv
src/operand_issue.sv
src/register_bank.sv
src/operand_collectors.sv
src/dispatch_arbiter.sv
src/operand_collector_top.sv
tests/oc_assertions.sv
tests/oc_tb.sv

// ==== tests/oc_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module oc_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input logic                      full,
    input logic [`OC_COLLECTORS-1:0] ready,
    input logic [`OC_COLLECTORS-1:0] grant,
    input logic                      alu_valid
);

    // the instruction buffer holds off while no collector is free
    no_issue_when_full: assert property (@(posedge clk) disable iff (!rst_n) !(in_valid && full))
        else $error("in_valid strobe while full is high");

    // one ready entry whenever any is ready
    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~ready) == '0) && ((grant != '0) == (ready != '0)))
        else $error("grant is not a single ready collector");

    alu_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !alu_valid)
        else $error("alu_valid high right after a reset cycle");

endmodule

bind operand_collector_top oc_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .full      (full),
    .ready     (ready),
    .grant     (grant),
    .alu_valid (alu_valid)
);

`default_nettype wire

// ==== tests/oc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "oc_params.svh"

module oc_tb;
    import oc_pkg::*;

    localparam int ROWS  = 1 << $bits(row_id_t);
    localparam int LIMIT = 400;                // cycles allowed for any one wait

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_t      in_instr;
    warp_id_t    in_warp;
    reg_idx_t    in_dst;
    alu_op_t     in_alu_op;
    reg_idx_t    in_src1;
    reg_idx_t    in_src2;
    logic        in_src1_valid;
    logic        in_src2_valid;
    logic [15:0] in_imm;
    logic        in_imm_valid;
    logic        full;
    logic        wb_valid;
    warp_id_t    wb_warp;
    reg_idx_t    wb_reg;
    lane_vec_t   wb_data;
    logic        alu_valid;
    instr_t      alu_instr;
    warp_id_t    alu_warp;
    reg_idx_t    alu_dst;
    alu_op_t     alu_op;
    lane_vec_t   alu_src1;
    lane_vec_t   alu_src2;

    lane_vec_t   shadow   [`OC_BANKS][ROWS];
    lane_vec_t   exp_src1 [instr_t];
    lane_vec_t   exp_src2 [instr_t];
    warp_id_t    exp_warp [instr_t];
    reg_idx_t    exp_dst  [instr_t];
    alu_op_t     exp_op   [instr_t];
    bit          seen     [instr_t];
    bit          locked   [`OC_WARPS][`OC_REGS];   // source of an instruction in flight
    logic [31:0] lfsr;
    instr_t      next_tag;
    int          issued;
    int          retired;
    int          checks;
    int          errors;
    int          cmp_errors;
    int          tests;
    bit          timed_out;

    operand_collector_top u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic lane_vec_t rand_vec();
        lane_vec_t v;
        for (int l = 0; l < `OC_LANES; l++) begin
            v[l*`OC_LANE_W +: `OC_LANE_W] = rand_bits(`OC_LANE_W);
        end
        return v;
    endfunction

    // expected operand: immediate wins, then register, else zero
    function automatic lane_vec_t ref_operand(input warp_id_t w, input reg_idx_t r,
                                              input logic use_reg, input logic use_imm,
                                              input logic [15:0] imm);
        phys_addr_u a;
        lane_vec_t  v;
        a.flat.warp = w;
        a.flat.idx  = r;
        v = '0;
        if (use_imm) begin
            for (int l = 0; l < `OC_LANES; l++) begin
                v[l*`OC_LANE_W +: `OC_LANE_W] = `OC_LANE_W'(imm);
            end
        end else if (use_reg) begin
            v = shadow[a.banked.bank][a.banked.row];
        end
        return v;
    endfunction

    task automatic check_vec(input string what, input lane_vec_t got, input lane_vec_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: tag %h %s = %h, expected %h", $time, alu_instr, what, got, exp);
            cmp_errors++;
        end
    endtask

    task automatic check_warp(input warp_id_t got, input warp_id_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: tag %h warp = %0d, expected %0d", $time, alu_instr, got, exp);
            cmp_errors++;
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: tag %h dst = %0d, expected %0d", $time, alu_instr, got, exp);
            cmp_errors++;
        end
    endtask

    task automatic check_op(input alu_op_t got, input alu_op_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: tag %h op = %h, expected %h", $time, alu_instr, got, exp);
            cmp_errors++;
        end
    endtask

    // scoreboard
    always @(negedge clk) begin
        if (rst_n && alu_valid) begin
            if (!exp_src1.exists(alu_instr)) begin
                $display("tag %h reached the ALU but was never issued", alu_instr);
                cmp_errors++;
            end else if (seen.exists(alu_instr)) begin
                $display("tag %h was dispatched more than once", alu_instr);
                cmp_errors++;
            end else begin
                seen[alu_instr] = 1'b1;
                check_vec("src1", alu_src1, exp_src1[alu_instr]);
                check_vec("src2", alu_src2, exp_src2[alu_instr]);
                check_warp(alu_warp, exp_warp[alu_instr]);
                check_reg(alu_dst, exp_dst[alu_instr]);
                check_op(alu_op, exp_op[alu_instr]);
                retired++;
            end
        end
    end

    task automatic write_reg(input warp_id_t w, input reg_idx_t r, input lane_vec_t d);
        phys_addr_u a;
        a.flat.warp = w;
        a.flat.idx  = r;
        wb_valid = 1'b1;
        wb_warp  = w;
        wb_reg   = r;
        wb_data  = d;
        shadow[a.banked.bank][a.banked.row] = d;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic issue_one(input warp_id_t w, input reg_idx_t s1, input logic s1v,
                             input reg_idx_t s2, input logic s2v,
                             input logic [15:0] imm, input logic immv);
        int     cnt;
        instr_t tag;
        cnt = 0;
        if (timed_out) return;
        while (full && cnt < LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (full) begin
            $display("timeout: full stayed high for %0d cycles", LIMIT);
            errors++;
            timed_out = 1'b1;
            return;
        end
        tag           = next_tag;
        next_tag      = next_tag + 1;
        in_instr      = tag;
        in_warp       = w;
        in_dst        = reg_idx_t'(rand_bits(3));
        in_alu_op     = alu_op_t'(rand_bits(4));
        in_src1       = s1;
        in_src1_valid = s1v;
        in_src2       = s2;
        in_src2_valid = s2v;
        in_imm        = imm;
        in_imm_valid  = immv;
        in_valid      = 1'b1;
        exp_src1[tag] = ref_operand(w, s1, s1v, 1'b0, imm);
        exp_src2[tag] = ref_operand(w, s2, s2v, immv, imm);
        exp_warp[tag] = w;
        exp_dst[tag]  = in_dst;
        exp_op[tag]   = in_alu_op;
        if (s1v) locked[w][s1] = 1'b1;
        if (s2v && !immv) locked[w][s2] = 1'b1;
        issued++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_random(input bit two_src, input bit imm_ok);
        warp_id_t    w;
        reg_idx_t    s1;
        reg_idx_t    s2;
        logic        s1v;
        logic        s2v;
        logic        immv;
        logic [15:0] imm;
        w    = warp_id_t'(rand_bits(3));
        s1   = reg_idx_t'(rand_bits(3));
        s2   = reg_idx_t'(rand_bits(3));
        s1v  = two_src | 1'(rand_bits(1));
        s2v  = two_src | 1'(rand_bits(1));
        immv = imm_ok & 1'(rand_bits(1));
        imm  = 16'(rand_bits(16));
        issue_one(w, s1, s1v, s2, s2v, imm, immv);
    endtask

    // two registers of one warp that live in the same bank
    task automatic issue_conflict(input bank_id_t b);
        phys_addr_u a1;
        phys_addr_u a2;
        a1.banked.bank   = b;
        a1.banked.row    = row_id_t'(rand_bits(4));
        a2               = a1;
        a2.banked.row[0] = ~a1.banked.row[0];
        issue_one(a1.flat.warp, a1.flat.idx, 1'b1, a2.flat.idx, 1'b1, 16'h0, 1'b0);
    endtask

    task automatic drain(input string what);
        int cnt;
        cnt = 0;
        if (timed_out) return;
        do begin
            @(posedge clk);
            cnt++;
        end while (retired != issued && cnt < LIMIT);
        if (retired != issued) begin
            $display("timeout: %0d instructions of %s never reached the ALU",
                     issued - retired, what);
            errors++;
            timed_out = 1'b1;
        end
        @(negedge clk);
        foreach (locked[w, r]) locked[w][r] = 1'b0;
    endtask

    task automatic end_test(input string name, input int e0, input int n0);
        tests++;
        $display("test %0d %-18s %3d instructions, %0d errors",
                 tests, name, issued - n0, errors + cmp_errors - e0);
    endtask

    task automatic run_two_source();
        int e0;
        int n0;
        e0 = errors + cmp_errors;
        n0 = issued;
        for (int w = 0; w < `OC_WARPS; w++) begin
            for (int r = 0; r < `OC_REGS; r++) begin
                write_reg(warp_id_t'(w), reg_idx_t'(r), rand_vec());
            end
        end
        for (int i = 0; i < 24; i++) issue_random(1'b1, 1'b0);
        drain("two-source reads");
        end_test("two-source reads", e0, n0);
    endtask

    task automatic run_immediate();
        int e0;
        int n0;
        e0 = errors + cmp_errors;
        n0 = issued;
        for (int i = 0; i < 16; i++) issue_random(1'b0, 1'b1);
        drain("immediates");
        end_test("immediates", e0, n0);
    endtask

    task automatic run_conflicts(input bit until_full);
        int       e0;
        int       n0;
        bank_id_t b;
        e0 = errors + cmp_errors;
        n0 = issued;
        b  = bank_id_t'(rand_bits(2));
        for (int i = 0; i < 32 && !timed_out && !(until_full && full); i++) begin
            if (!until_full && i == 12) break;
            issue_conflict(b);
        end
        if (until_full && !full) begin
            $display("** Error @ %0t: full never rose during back-to-back issue", $time);
            errors++;
        end
        drain(until_full ? "full flag" : "bank conflicts");
        if (full) begin
            $display("** Error @ %0t: full still high with every collector idle", $time);
            errors++;
        end
        end_test(until_full ? "full flag" : "bank conflicts", e0, n0);
    endtask

    task automatic run_random();
        int        e0;
        int        n0;
        warp_id_t  w;
        reg_idx_t  r;
        lane_vec_t d;
        e0 = errors + cmp_errors;
        n0 = issued;
        for (int i = 0; i < 300; i++) begin
            if (rand_bits(1) != 0) begin
                w = warp_id_t'(rand_bits(3));
                r = reg_idx_t'(rand_bits(3));
                d = rand_vec();
                if (locked[w][r]) begin
                    @(negedge clk);            // would race a pending read
                end else begin
                    write_reg(w, r, d);
                end
            end else begin
                issue_random(1'b0, 1'b1);
            end
            if (i % 60 == 59) drain("random traffic");
        end
        drain("random traffic");
        end_test("random traffic", e0, n0);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_warp       = '0;
        in_dst        = '0;
        in_alu_op     = '0;
        in_src1       = '0;
        in_src2       = '0;
        in_src1_valid = 1'b0;
        in_src2_valid = 1'b0;
        in_imm        = '0;
        in_imm_valid  = 1'b0;
        wb_valid      = 1'b0;
        wb_warp       = '0;
        wb_reg        = '0;
        wb_data       = '0;
        lfsr          = 32'h8ea1;
        next_tag      = 32'h0000_0100;
        foreach (shadow[b, r]) shadow[b][r] = '0;
        foreach (locked[w, r]) locked[w][r] = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        run_two_source();
        run_immediate();
        run_conflicts(1'b0);
        run_conflicts(1'b1);
        run_random();
        $display("%0d tests, %0d issued, %0d dispatched, %0d checks, %0d errors",
                 tests, issued, retired, checks, errors + cmp_errors);
        if (errors + cmp_errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
